//--- files.f
logic/core_pkg.sv
logic/operand_read.sv
logic/alu_lane.sv
logic/retire_merge.sv
logic/dual_issue_core.sv
dv/clock_gen.sv
dv/core_tb.sv

//--- Makefile
# Verilator build for the dual-issue core back end

TOP := core_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall -f files.f --top-module dual_issue_core

sim:
	verilator --binary --timing -f files.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "Simulation PASSED" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

//--- dv/core_tb.sv
`timescale 1ns/1ns

module core_tb import core_pkg::*; ();

    localparam int LANES          = 2;
    localparam int RAND_PAIRS     = 400;
    localparam int DIRECTED_PAIRS = 17;
    localparam int DUMPS          = 6;
    // a dump is 32 reads and a closing cycle and a drain is 2 cycles
    localparam int TIMEOUT_CYCLES = 2 + DIRECTED_PAIRS + RAND_PAIRS + DUMPS * (33 + 2) + 100;

    logic                  clk;
    logic                  reset;
    logic                  valid;
    alu_op_t   [LANES-1:0] op;
    reg_addr_t [LANES-1:0] rs;
    reg_addr_t [LANES-1:0] rt;
    reg_addr_t [LANES-1:0] rd;
    reg_addr_t             dbg_addr;
    word_t                 dbg_data;
    word_t                 hi;
    word_t                 lo;

    // reference state
    word_t       model_regs [32];
    dword_t      model_hilo;
    logic [31:0] lfsr_state;

    // compare requests set on the rising edge and checked on the falling edge
    logic   cmp_en;
    string  cmp_name;
    word_t  cmp_reg;
    dword_t cmp_hilo;
    int     check_count = 0;
    int     cycle_count = 0;

    clock_gen #(.PERIOD(100), .RESET_CYCLES(2)) u_clock_gen (
        .o_clk   (clk),
        .o_reset (reset)
    );

    dual_issue_core #(.NUM_LANES(LANES)) u_dual_issue_core (
        .clk        (clk),
        .reset      (reset),
        .i_valid    (valid),
        .i_op       (op),
        .i_rs       (rs),
        .i_rt       (rt),
        .i_rd       (rd),
        .i_dbg_addr (dbg_addr),
        .o_dbg_data (dbg_data),
        .o_hi       (hi),
        .o_lo       (lo)
    );

    // galois form shifting right
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hD000_0001;
        end else begin
            return s >> 1;
        end
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    // apply one pair to the model where both lanes read the state from before the pair
    function automatic void model_pair(input alu_op_t [LANES-1:0] ops,
                                       input reg_addr_t [LANES-1:0] srcs,
                                       input reg_addr_t [LANES-1:0] srct,
                                       input reg_addr_t [LANES-1:0] dsts);
        word_t  pre_regs [32];
        dword_t pre_hilo;
        word_t  a;
        word_t  b;
        word_t  res;
        dword_t prod;
        logic   writes_rd;
        pre_regs = model_regs;
        pre_hilo = model_hilo;
        for (int l = 0; l < LANES; l++) begin
            a    = pre_regs[srcs[l]];
            b    = pre_regs[srct[l]];
            prod = {32'h0, a} * {32'h0, b};
            res  = '0;
            writes_rd = ops[l] inside {OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_XOR, OP_SLT,
                                       OP_MFHI, OP_MFLO};
            case (ops[l])
                OP_ADDU:  res = a + b;
                OP_SUBU:  res = a - b;
                OP_AND:   res = a & b;
                OP_OR:    res = a | b;
                OP_XOR:   res = a ^ b;
                OP_SLT:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                OP_MFHI:  res = pre_hilo[63:32];
                OP_MFLO:  res = pre_hilo[31:0];
                OP_MULTU: model_hilo = prod;
                OP_MADDU: model_hilo = pre_hilo + prod;
                OP_MSUBU: model_hilo = pre_hilo - prod;
                OP_MTHI:  model_hilo[63:32] = a;
                OP_MTLO:  model_hilo[31:0] = a;
                default:  ;
            endcase
            // younger lane lands last and r0 stays zero
            if (writes_rd && (dsts[l] != 5'd0)) begin
                model_regs[dsts[l]] = res;
            end
        end
    endfunction

    task automatic check_value(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("[ERROR] %s expected 0x%08h actual 0x%08h", name, exp, act);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch");
        end else begin
            check_count++;
        end
    endtask

    task automatic send_pair(input alu_op_t op0, input reg_addr_t rs0, input reg_addr_t rt0,
                             input reg_addr_t rd0, input alu_op_t op1, input reg_addr_t rs1,
                             input reg_addr_t rt1, input reg_addr_t rd1);
        alu_op_t [LANES-1:0] ops;
        ops[0] = op0;
        ops[1] = op1;
        @(posedge clk);
        valid <= 1'b1;
        op[0] <= op0;
        op[1] <= op1;
        rs    <= {rs1, rs0};
        rt    <= {rt1, rt0};
        rd    <= {rd1, rd0};
        model_pair(ops, {rs1, rs0}, {rt1, rt0}, {rd1, rd0});
    endtask

    // last pair retires two edges after it was driven
    task automatic drain();
        @(posedge clk);
        valid <= 1'b0;
        op[0] <= OP_NOP;
        op[1] <= OP_NOP;
        @(posedge clk);
    endtask

    task automatic dump_regs(input string name);
        for (int r = 0; r < 32; r++) begin
            @(posedge clk);
            dbg_addr <= reg_addr_t'(r);
            cmp_name <= name;
            cmp_reg  <= model_regs[r];
            cmp_hilo <= model_hilo;
            cmp_en   <= 1'b1;
        end
        @(posedge clk);
        cmp_en <= 1'b0;
    endtask

    always @(negedge clk) begin
        if (cmp_en) begin
            check_value($sformatf("%s r%0d", cmp_name, dbg_addr), cmp_reg, dbg_data);
            check_value({cmp_name, " hi"}, cmp_hilo[63:32], hi);
            check_value({cmp_name, " lo"}, cmp_hilo[31:0], lo);
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        word_t       v;
        logic [31:0] sel0;
        logic [31:0] sel1;
        valid      = 1'b0;
        op[0]      = OP_NOP;
        op[1]      = OP_NOP;
        rs         = '0;
        rt         = '0;
        rd         = '0;
        dbg_addr   = '0;
        cmp_en     = 1'b0;
        cmp_reg    = '0;
        cmp_hilo   = '0;
        lfsr_state = 32'd87744;
        model_hilo = HILO_RESET;
        foreach (model_regs[r]) begin
            model_regs[r] = '0;
        end
        while (reset) @(posedge clk);

        dump_regs("reset");

        // seed the register file through the hierarchy as no op loads a constant
        @(negedge clk);
        for (int r = 1; r < 32; r++) begin
            v = take_bits(32);
            u_dual_issue_core.u_operand_read.regs[r] = v;
            model_regs[r] = v;
        end

        send_pair(OP_ADDU, 1, 2, 3, OP_SUBU, 4, 5, 6);
        send_pair(OP_AND, 7, 8, 9, OP_OR, 10, 11, 12);
        send_pair(OP_XOR, 13, 14, 15, OP_SLT, 16, 17, 18);
        send_pair(OP_SLT, 17, 16, 19, OP_ADDU, 1, 2, 0);
        drain();
        dump_regs("alu");

        send_pair(OP_ADDU, 1, 2, 20, OP_SUBU, 3, 4, 20);
        send_pair(OP_MTHI, 5, 0, 0, OP_MTHI, 6, 0, 0);
        drain();
        dump_regs("same_dest");

        send_pair(OP_ADDU, 1, 2, 21, OP_XOR, 3, 4, 22);
        send_pair(OP_SUBU, 21, 22, 23, OP_ADDU, 21, 21, 24);
        send_pair(OP_OR, 23, 24, 25, OP_AND, 23, 21, 26);
        drain();
        dump_regs("forward");

        send_pair(OP_MULTU, 1, 2, 0, OP_NOP, 0, 0, 0);
        send_pair(OP_MADDU, 3, 4, 0, OP_MFHI, 0, 0, 27);
        send_pair(OP_MSUBU, 5, 6, 0, OP_MFLO, 0, 0, 28);
        send_pair(OP_MTLO, 7, 0, 0, OP_MFHI, 0, 0, 29);
        send_pair(OP_MFLO, 0, 0, 30, OP_MADDU, 8, 9, 0);
        send_pair(OP_MTHI, 10, 0, 0, OP_MTLO, 11, 0, 0);
        send_pair(OP_MSUBU, 12, 13, 0, OP_MFHI, 0, 0, 31);
        send_pair(OP_MFLO, 0, 0, 27, OP_MFHI, 0, 0, 28);
        drain();
        dump_regs("hilo");

        // random pairs over r0 to r7
        for (int p = 0; p < RAND_PAIRS; p++) begin
            sel0 = take_bits(4) % 14;
            sel1 = take_bits(4) % 14;
            send_pair(alu_op_t'(sel0[3:0]), reg_addr_t'(take_bits(3)),
                      reg_addr_t'(take_bits(3)), reg_addr_t'(take_bits(3)),
                      alu_op_t'(sel1[3:0]), reg_addr_t'(take_bits(3)),
                      reg_addr_t'(take_bits(3)), reg_addr_t'(take_bits(3)));
        end
        drain();
        dump_regs("random");

        @(negedge clk);
        if (check_count > 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("no checks were run");
            $display("Simulation FAILED");
            $fatal(1, "no checks");
        end
    end

endmodule

//--- dv/clock_gen.sv
`timescale 1ns/1ns

module clock_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 2
) (
    output logic o_clk,
    output logic o_reset
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD / 2);
            o_clk = ~o_clk;
        end
    end

    // released on a rising edge, so the DUT sees it high on RESET_CYCLES edges
    initial begin
        o_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_reset <= 1'b0;
    end

endmodule

//--- logic/dual_issue_core.sv
`timescale 1ns/1ns

module dual_issue_core import core_pkg::*; #(
    parameter int NUM_LANES = LANE_COUNT
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      i_valid,
    input  alu_op_t   [NUM_LANES-1:0] i_op,
    input  reg_addr_t [NUM_LANES-1:0] i_rs,
    input  reg_addr_t [NUM_LANES-1:0] i_rt,
    input  reg_addr_t [NUM_LANES-1:0] i_rd,
    input  reg_addr_t                 i_dbg_addr,
    output word_t                     o_dbg_data,
    output word_t                     o_hi,
    output word_t                     o_lo
);

    // operand stage to lanes
    word_t     [NUM_LANES-1:0] rs_val;
    word_t     [NUM_LANES-1:0] rt_val;
    dword_t                    hilo_fwd;
    dword_t                    hilo_q;

    // lane registers to retire
    logic      [NUM_LANES-1:0] lane_rf_wr;
    reg_addr_t [NUM_LANES-1:0] lane_rf_addr;
    word_t     [NUM_LANES-1:0] lane_rf_data;
    logic      [NUM_LANES-1:0] lane_hi_wr;
    logic      [NUM_LANES-1:0] lane_lo_wr;
    dword_t    [NUM_LANES-1:0] lane_hilo_val;

    // merged writes back to storage
    logic      [NUM_LANES-1:0] wr_en;
    reg_addr_t [NUM_LANES-1:0] wr_addr;
    word_t     [NUM_LANES-1:0] wr_data;
    logic                      hi_wr;
    logic                      lo_wr;
    dword_t                    hilo_next;

    operand_read #(.NUM_LANES(NUM_LANES)) u_operand_read (
        .clk         (clk),
        .reset       (reset),
        .i_rs        (i_rs),
        .i_rt        (i_rt),
        .i_wr_en     (wr_en),
        .i_wr_addr   (wr_addr),
        .i_wr_data   (wr_data),
        .i_hi_wr     (hi_wr),
        .i_lo_wr     (lo_wr),
        .i_hilo_next (hilo_next),
        .i_dbg_addr  (i_dbg_addr),
        .o_rs_val    (rs_val),
        .o_rt_val    (rt_val),
        .o_hilo      (hilo_fwd),
        .o_hilo_q    (hilo_q),
        .o_dbg_data  (o_dbg_data)
    );

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        alu_lane u_alu_lane (
            .clk        (clk),
            .reset      (reset),
            .i_valid    (i_valid),
            .i_op       (i_op[g]),
            .i_rd       (i_rd[g]),
            .i_rs_val   (rs_val[g]),
            .i_rt_val   (rt_val[g]),
            .i_hilo     (hilo_fwd),
            .o_rf_wr    (lane_rf_wr[g]),
            .o_rf_addr  (lane_rf_addr[g]),
            .o_rf_data  (lane_rf_data[g]),
            .o_hi_wr    (lane_hi_wr[g]),
            .o_lo_wr    (lane_lo_wr[g]),
            .o_hilo_val (lane_hilo_val[g])
        );
    end

    retire_merge #(.NUM_LANES(NUM_LANES)) u_retire_merge (
        .i_rf_wr     (lane_rf_wr),
        .i_rf_addr   (lane_rf_addr),
        .i_rf_data   (lane_rf_data),
        .i_hi_wr     (lane_hi_wr),
        .i_lo_wr     (lane_lo_wr),
        .i_hilo_val  (lane_hilo_val),
        .i_hilo_q    (hilo_q),
        .o_wr_en     (wr_en),
        .o_wr_addr   (wr_addr),
        .o_wr_data   (wr_data),
        .o_hi_wr     (hi_wr),
        .o_lo_wr     (lo_wr),
        .o_hilo_next (hilo_next)
    );

    assign o_hi = hilo_q[63:32];
    assign o_lo = hilo_q[31:0];

endmodule

//--- logic/retire_merge.sv
`timescale 1ns/1ns

module retire_merge import core_pkg::*; #(
    parameter int NUM_LANES = LANE_COUNT
) (
    input  logic      [NUM_LANES-1:0] i_rf_wr,
    input  reg_addr_t [NUM_LANES-1:0] i_rf_addr,
    input  word_t     [NUM_LANES-1:0] i_rf_data,
    input  logic      [NUM_LANES-1:0] i_hi_wr,
    input  logic      [NUM_LANES-1:0] i_lo_wr,
    input  dword_t    [NUM_LANES-1:0] i_hilo_val,
    input  dword_t                    i_hilo_q,
    output logic      [NUM_LANES-1:0] o_wr_en,
    output reg_addr_t [NUM_LANES-1:0] o_wr_addr,
    output word_t     [NUM_LANES-1:0] o_wr_data,
    output logic                      o_hi_wr,
    output logic                      o_lo_wr,
    output dword_t                    o_hilo_next
);

    word_t hi_next;
    word_t lo_next;

    // drop a write when any younger lane hits the same register
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            o_wr_en[i] = i_rf_wr[i];
            for (int j = i + 1; j < NUM_LANES; j++) begin
                if (i_rf_wr[j] && (i_rf_addr[j] == i_rf_addr[i])) begin
                    o_wr_en[i] = 1'b0;
                end
            end
        end
    end

    assign o_wr_addr = i_rf_addr;
    assign o_wr_data = i_rf_data;

    // walk oldest to youngest, the last writer of each half wins
    always_comb begin
        hi_next = i_hilo_q[63:32];
        lo_next = i_hilo_q[31:0];
        o_hi_wr = 1'b0;
        o_lo_wr = 1'b0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (i_hi_wr[i]) begin
                hi_next = i_hilo_val[i][63:32];
                o_hi_wr = 1'b1;
            end
            if (i_lo_wr[i]) begin
                lo_next = i_hilo_val[i][31:0];
                o_lo_wr = 1'b1;
            end
        end
    end

    assign o_hilo_next = {hi_next, lo_next};

endmodule

//--- logic/alu_lane.sv
`timescale 1ns/1ns

module alu_lane import core_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      i_valid,
    input  alu_op_t   i_op,
    input  reg_addr_t i_rd,
    input  word_t     i_rs_val,
    input  word_t     i_rt_val,
    input  dword_t    i_hilo,
    output logic      o_rf_wr,
    output reg_addr_t o_rf_addr,
    output word_t     o_rf_data,
    output logic      o_hi_wr,
    output logic      o_lo_wr,
    output dword_t    o_hilo_val
);

    logic   rf_wr;
    logic   hi_wr;
    logic   lo_wr;
    word_t  rf_data;
    dword_t hilo_val;
    dword_t product;

    // unsigned 64-bit product
    assign product = dword_t'(i_rs_val) * dword_t'(i_rt_val);

    always_comb begin
        rf_wr    = 1'b0;
        hi_wr    = 1'b0;
        lo_wr    = 1'b0;
        rf_data  = '0;
        hilo_val = i_hilo;
        case (i_op)
            OP_ADDU:  begin rf_wr = 1'b1; rf_data = i_rs_val + i_rt_val; end
            OP_SUBU:  begin rf_wr = 1'b1; rf_data = i_rs_val - i_rt_val; end
            OP_AND:   begin rf_wr = 1'b1; rf_data = i_rs_val & i_rt_val; end
            OP_OR:    begin rf_wr = 1'b1; rf_data = i_rs_val | i_rt_val; end
            OP_XOR:   begin rf_wr = 1'b1; rf_data = i_rs_val ^ i_rt_val; end
            OP_SLT: begin
                rf_wr   = 1'b1;
                rf_data = word_t'($signed(i_rs_val) < $signed(i_rt_val));
            end
            // accumulate over the forwarded hi/lo
            OP_MULTU: begin hi_wr = 1'b1; lo_wr = 1'b1; hilo_val = product; end
            OP_MADDU: begin hi_wr = 1'b1; lo_wr = 1'b1; hilo_val = i_hilo + product; end
            OP_MSUBU: begin hi_wr = 1'b1; lo_wr = 1'b1; hilo_val = i_hilo - product; end
            OP_MTHI:  begin hi_wr = 1'b1; hilo_val[63:32] = i_rs_val; end
            OP_MTLO:  begin lo_wr = 1'b1; hilo_val[31:0] = i_rs_val; end
            OP_MFHI:  begin rf_wr = 1'b1; rf_data = i_hilo[63:32]; end
            OP_MFLO:  begin rf_wr = 1'b1; rf_data = i_hilo[31:0]; end
            default:  ;
        endcase
    end

    // write flags, cleared when no pair is present
    always_ff @(posedge clk) begin
        if (reset) begin
            o_rf_wr <= 1'b0;
            o_hi_wr <= 1'b0;
            o_lo_wr <= 1'b0;
        end else begin
            o_rf_wr <= i_valid & rf_wr;
            o_hi_wr <= i_valid & hi_wr;
            o_lo_wr <= i_valid & lo_wr;
        end
    end

    // payload for retire
    always_ff @(posedge clk) begin
        o_rf_addr  <= i_rd;
        o_rf_data  <= rf_data;
        o_hilo_val <= hilo_val;
    end

endmodule

//--- logic/operand_read.sv
`timescale 1ns/1ns

module operand_read import core_pkg::*; #(
    parameter int NUM_LANES = LANE_COUNT
) (
    input  logic                          clk,
    input  logic                          reset,
    input  reg_addr_t [NUM_LANES-1:0]     i_rs,
    input  reg_addr_t [NUM_LANES-1:0]     i_rt,
    input  logic      [NUM_LANES-1:0]     i_wr_en,
    input  reg_addr_t [NUM_LANES-1:0]     i_wr_addr,
    input  word_t     [NUM_LANES-1:0]     i_wr_data,
    input  logic                          i_hi_wr,
    input  logic                          i_lo_wr,
    input  dword_t                        i_hilo_next,
    input  reg_addr_t                     i_dbg_addr,
    output word_t     [NUM_LANES-1:0]     o_rs_val,
    output word_t     [NUM_LANES-1:0]     o_rt_val,
    output dword_t                        o_hilo,
    output dword_t                        o_hilo_q,
    output word_t                         o_dbg_data
);

    word_t  regs [32];
    dword_t hilo_q;

    // stored value, overridden by pending retire writes
    // later lanes are younger, so the last match wins
    function automatic word_t fwd_read(input reg_addr_t addr);
        word_t val;
        val = regs[addr];
        for (int w = 0; w < NUM_LANES; w++) begin
            if (i_wr_en[w] && (i_wr_addr[w] != '0) && (i_wr_addr[w] == addr)) begin
                val = i_wr_data[w];
            end
        end
        return val;
    endfunction

    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            o_rs_val[l] = fwd_read(i_rs[l]);
            o_rt_val[l] = fwd_read(i_rt[l]);
        end
    end

    // hi/lo halves forwarded separately
    assign o_hilo[63:32] = i_hi_wr ? i_hilo_next[63:32] : hilo_q[63:32];
    assign o_hilo[31:0]  = i_lo_wr ? i_hilo_next[31:0]  : hilo_q[31:0];

    assign o_hilo_q   = hilo_q;
    assign o_dbg_data = regs[i_dbg_addr];

    // commit merged writes, r0 is never written
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < 32; r++) begin
                regs[r] <= REG_RESET;
            end
        end else begin
            for (int w = 0; w < NUM_LANES; w++) begin
                if (i_wr_en[w] && (i_wr_addr[w] != '0)) begin
                    regs[i_wr_addr[w]] <= i_wr_data[w];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hilo_q <= HILO_RESET;
        end else begin
            if (i_hi_wr) begin
                hilo_q[63:32] <= i_hilo_next[63:32];
            end
            if (i_lo_wr) begin
                hilo_q[31:0] <= i_hilo_next[31:0];
            end
        end
    end

endmodule

//--- logic/core_pkg.sv
package core_pkg;

    // data widths
    typedef logic [31:0] word_t;
    typedef logic [63:0] dword_t;
    typedef logic [4:0]  reg_addr_t;

    // decoded ops, one per issue slot
    typedef enum logic [3:0] {
        OP_NOP,
        OP_ADDU,
        OP_SUBU,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_MULTU,
        OP_MADDU,
        OP_MSUBU,
        OP_MTHI,
        OP_MTLO,
        OP_MFHI,
        OP_MFLO
    } alu_op_t;

    // default issue width
    localparam int LANE_COUNT = 2;

    // reset values of architectural state
    localparam word_t  REG_RESET  = 32'h0;
    localparam dword_t HILO_RESET = 64'h0;

endpackage
